//--- compile.f
lcd_pkg.sv
lcd_clk_gen.sv
lcd_frame_ram.sv
lcd_reg_bus.sv
lcd_scan_timing.sv
lcd_ctrl_top.sv
tb_lcd_ctrl.sv

//--- run_sim.sh
#!/bin/bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_lcd_ctrl \
	-f compile.f -o tb_lcd_ctrl \
	&& ./obj_dir/tb_lcd_ctrl > sim.log 2>&1 \
	|| echo "Testbench failed" >> sim.log
cat sim.log
if grep -q "Testbench failed" sim.log; then
	exit 1
fi
exit 0

//--- tb_lcd_ctrl.sv
`timescale 1ns/1ps

module tb_lcd_ctrl import lcd_pkg::*; ();

	localparam int timeout_cycles = 20000;

	logic clk;
	logic rst_n;
	logic wen;
	logic [page_addr_bits-1:0] waddr;
	logic [data_width-1:0] wdata;
	logic [bytes_per_word-1:0] wstrb;
	logic ren;
	logic [page_addr_bits-1:0] raddr;
	logic [data_width-1:0] rdata;
	logic lcm_din;
	logic lcm_lp;
	logic lcm_xscl;
	logic [byte_width-1:0] lcm_data;

	logic [data_width-1:0] model_mem [0:frame_words-1];
	integer seed;
	int checks = 0;
	int errors = 0;

	// Panel monitor state.
	int cyc = 0;
	int frames_done = 0;
	int line_idx = 0;
	int byte_idx = 0;
	int last_rise = 0;
	int min_gap = 0;
	int max_gap = 0;
	logic [byte_width-1:0] cap_bytes [0:frame_bytes-1];
	int line_len [0:panel_height-1];
	logic din_any [0:panel_height-1];
	logic din_all [0:panel_height-1];
	logic xscl_q = 1'b0;
	logic lp_q = 1'b0;
	logic din_q = 1'b0;

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	lcd_ctrl_top dut (
		.clk(clk),
		.rst_n(rst_n),
		.wen(wen),
		.waddr(waddr),
		.wdata(wdata),
		.wstrb(wstrb),
		.ren(ren),
		.raddr(raddr),
		.rdata(rdata),
		.lcm_din(lcm_din),
		.lcm_lp(lcm_lp),
		.lcm_xscl(lcm_xscl),
		.lcm_data(lcm_data)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Panel monitor
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always @(posedge clk) begin
		cyc <= cyc + 1;
	end

	always @(negedge clk) begin
		int gap;
		if (lcm_din && !din_q) begin
			line_idx = 0; // New frame.
			byte_idx = 0;
			min_gap = 1 << 30;
			max_gap = 0;
			for (int l = 0; l < panel_height; l++) begin
				line_len[l] = 0;
				din_any[l] = 1'b0;
				din_all[l] = 1'b1;
			end
		end
		if (lcm_xscl && !xscl_q) begin
			if (byte_idx > 0) begin
				gap = cyc - last_rise;
				min_gap = (gap < min_gap) ? gap : min_gap;
				max_gap = (gap > max_gap) ? gap : max_gap;
			end
			last_rise = cyc;
			if (line_idx < panel_height && byte_idx < line_bytes) begin
				cap_bytes[line_idx * line_bytes + byte_idx] = lcm_data;
				din_any[line_idx] = din_any[line_idx] | lcm_din;
				din_all[line_idx] = din_all[line_idx] & lcm_din;
			end
			byte_idx++;
		end
		if (lcm_lp && !lp_q) begin
			if (line_idx < panel_height) begin
				line_len[line_idx] = byte_idx;
			end
			line_idx++;
			byte_idx = 0;
			if (line_idx == panel_height) begin
				frames_done++; // Last line latched.
			end
		end
		din_q = lcm_din;
		xscl_q = lcm_xscl;
		lp_q = lcm_lp;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Bus and check tasks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic check_value(input string name, input logic [data_width-1:0] got,
			input logic [data_width-1:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic bus_write(input logic [page_addr_bits-1:0] addr,
			input logic [data_width-1:0] data, input logic [bytes_per_word-1:0] strb);
		@(negedge clk);
		wen = 1'b1;
		waddr = addr;
		wdata = data;
		wstrb = strb;
		@(negedge clk);
		wen = 1'b0;
	endtask

	// Mirrors the page window rule in the model before the bus write.
	task automatic write_word(input int page, input int addr, input logic [data_width-1:0] data,
			input logic [bytes_per_word-1:0] strb);
		int idx;
		idx = (page - 1) * page_words + addr;
		for (int k = 0; k < bytes_per_word; k++) begin
			if (strb[k]) begin
				model_mem[idx][k*byte_width +: byte_width] = data[k*byte_width +: byte_width];
			end
		end
		bus_write(page_addr_bits'(addr), data, strb);
	endtask

	task automatic bus_read_check(input logic [page_addr_bits-1:0] addr,
			input logic [data_width-1:0] exp, input string name);
		@(negedge clk);
		ren = 1'b1;
		raddr = addr;
		@(negedge clk);
		ren = 1'b0;
		check_value(name, rdata, exp);
		@(negedge clk);
		check_value({name, " held"}, rdata, exp); // No ren, no change.
	endtask

	task automatic fill_frame();
		for (int p = 1; p < num_pages; p++) begin
			bus_write(reg_write_page, p, 4'hf);
			for (int a = 0; a < page_words; a++) begin
				write_word(p, a, $random(seed), 4'hf);
			end
		end
	endtask

	task automatic rewrite_last_word();
		bus_write(reg_write_page, num_pages - 1, 4'hf);
		write_word(num_pages - 1, page_words - 1, $random(seed), 4'hf);
	endtask

	task automatic wait_frame(input int start_count);
		int n;
		n = 0;
		while (frames_done == start_count && n < timeout_cycles) begin
			@(posedge clk);
			n++;
		end
		checks++;
		assert (frames_done > start_count) else begin
			$display("Timeout: no complete refresh frame within %0d cycles", timeout_cycles);
			errors++;
		end
	endtask

	function automatic logic [byte_width-1:0] reverse_bits(input logic [byte_width-1:0] b);
		logic [byte_width-1:0] r;
		for (int k = 0; k < byte_width; k++) begin
			r[k] = b[byte_width-1-k];
		end
		return r;
	endfunction

	task automatic check_frame(input logic order, input int delay);
		logic [byte_width-1:0] exp;
		check_value("lines captured", line_idx, panel_height);
		for (int l = 0; l < panel_height; l++) begin
			check_value($sformatf("line %0d byte count", l), line_len[l], line_bytes);
			check_value($sformatf("lcm_din in line %0d", l),
				32'((l == 0) ? din_all[l] : din_any[l]), 32'(l == 0));
		end
		for (int i = 0; i < frame_bytes; i++) begin
			exp = model_mem[i / bytes_per_word][(i % bytes_per_word)*byte_width +: byte_width];
			if (order) begin
				exp = reverse_bits(exp);
			end
			check_value($sformatf("lcm_data byte %0d", i), 32'(cap_bytes[i]), 32'(exp));
		end
		// Low phase plus high phase, each one clk_delay long.
		check_value("xscl rise spacing min", min_gap, 2 * delay);
		check_value("xscl rise spacing max", max_gap, 2 * delay);
	endtask

	task automatic report_test(input string name, input int errors_before);
		$display("Test %s finished with %0d errors", name, errors - errors_before);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Tests
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic test_registers();
		int e0;
		e0 = errors;
		bus_read_check(reg_clk_delay, min_clk_delay, "clk_delay");
		bus_read_check(reg_byte_order, 0, "byte_order");
		bus_read_check(reg_read_page, 0, "read_page");
		bus_read_check(reg_write_page, 0, "write_page");
		bus_read_check(4'd9, {bad_addr_tag, 24'd9}, "unmapped read");
		bus_write(reg_clk_delay, 0, 4'hf);
		bus_read_check(reg_clk_delay, min_clk_delay, "clamped clk_delay");
		bus_write(reg_write_page, 5, 4'hf);
		bus_read_check(reg_write_page, 0, "write_page after value 5");
		bus_write(reg_read_page, 5, 4'hf);
		// A register answer only comes back while read_page is still 0.
		bus_read_check(reg_clk_delay, min_clk_delay, "clk_delay after read_page value 5");
		report_test("registers", e0);
	endtask

	task automatic test_paged_access();
		int e0;
		e0 = errors;
		bus_write(reg_read_page, 1, 4'hf);
		bus_write(reg_write_page, 1, 4'hf);
		for (int a = 0; a < page_words - 1; a++) begin
			write_word(1, a, $random(seed), 4'hf);
		end
		for (int a = 0; a < page_words - 1; a++) begin
			write_word(1, a, $random(seed), 4'($random(seed)));
		end
		write_word(1, page_words - 1, $random(seed), 4'b0111); // Page stays.
		write_word(1, page_words - 1, $random(seed), 4'b1000); // Page returns to 0.
		for (int a = 0; a < page_words; a++) begin
			bus_read_check(page_addr_bits'(a), model_mem[a], $sformatf("rdata word %0d", a));
		end
		bus_write(reg_read_page, 0, 4'hf);
		bus_read_check(reg_write_page, 0, "write_page after word 15");
		bus_read_check(reg_read_page, 0, "read_page");
		report_test("paged access", e0);
	endtask

	task automatic test_full_refresh();
		int e0;
		int start;
		e0 = errors;
		start = frames_done;
		fill_frame();
		wait_frame(start);
		check_frame(1'b0, 1);
		report_test("full refresh", e0);
	endtask

	task automatic test_byte_order();
		int e0;
		int start;
		e0 = errors;
		bus_write(reg_byte_order, 1, 4'hf);
		bus_read_check(reg_byte_order, 1, "byte_order");
		start = frames_done;
		rewrite_last_word();
		wait_frame(start);
		check_frame(1'b1, 1);
		report_test("byte order", e0);
	endtask

	task automatic test_clock_delay();
		int e0;
		int start;
		e0 = errors;
		bus_write(reg_byte_order, 0, 4'hf);
		bus_write(reg_clk_delay, 4, 4'hf);
		bus_read_check(reg_clk_delay, 4, "clk_delay");
		start = frames_done;
		rewrite_last_word();
		wait_frame(start);
		check_frame(1'b0, 4);
		report_test("clock delay", e0);
	endtask

	initial begin
		seed = 32'hd4df;
		rst_n = 1'b0;
		wen = 1'b0;
		waddr = '0;
		wdata = '0;
		wstrb = '0;
		ren = 1'b0;
		raddr = '0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		check_value("rdata after reset", rdata, '0);
		test_registers();
		test_paged_access();
		test_full_refresh();
		test_byte_order();
		test_clock_delay();
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

//--- lcd_ctrl_top.sv
`timescale 1ns/1ps

module lcd_ctrl_top import lcd_pkg::*; (
	input  logic                      clk,
	input  logic                      rst_n,

	input  logic                      wen,
	input  logic [page_addr_bits-1:0] waddr,
	input  logic [data_width-1:0]     wdata,
	input  logic [bytes_per_word-1:0] wstrb,
	input  logic                      ren,
	input  logic [page_addr_bits-1:0] raddr,
	output logic [data_width-1:0]     rdata,

	output logic                      lcm_din,
	output logic                      lcm_lp,
	output logic                      lcm_xscl,
	output logic [byte_width-1:0]     lcm_data
);

	logic ram_we;
	logic [ram_addr_bits-1:0] ram_waddr;
	logic [data_width-1:0] ram_wdata;
	logic [bytes_per_word-1:0] ram_wstrb;
	logic ram_re;
	logic [ram_addr_bits-1:0] ram_raddr;
	logic [data_width-1:0] ram_rdata;

	logic [data_width-1:0] clk_delay;
	logic byte_order;
	logic refresh_req;
	logic clk_event;
	logic [7:0] byte_index;

	lcd_reg_bus u_reg_bus (
		.clk(clk),
		.rst_n(rst_n),
		.wen(wen),
		.waddr(waddr),
		.wdata(wdata),
		.wstrb(wstrb),
		.ren(ren),
		.raddr(raddr),
		.rdata(rdata),
		.ram_we(ram_we),
		.ram_waddr(ram_waddr),
		.ram_wdata(ram_wdata),
		.ram_wstrb(ram_wstrb),
		.ram_re(ram_re),
		.ram_raddr(ram_raddr),
		.ram_rdata(ram_rdata),
		.clk_delay(clk_delay),
		.byte_order(byte_order),
		.refresh_req(refresh_req)
	);

	lcd_frame_ram u_frame_ram (
		.clk(clk),
		.we(ram_we),
		.waddr(ram_waddr),
		.wdata(ram_wdata),
		.wstrb(ram_wstrb),
		.re(ram_re),
		.raddr(ram_raddr),
		.rdata(ram_rdata),
		.byte_index(byte_index),
		.byte_order(byte_order),
		.scan_byte(lcm_data)
	);

	lcd_clk_gen u_clk_gen (
		.clk(clk),
		.rst_n(rst_n),
		.clk_delay(clk_delay),
		.panel_clk(),
		.clk_event(clk_event)
	);

	lcd_scan_timing u_scan_timing (
		.clk(clk),
		.rst_n(rst_n),
		.refresh_req(refresh_req),
		.clk_event(clk_event),
		.din(lcm_din),
		.lp(lcm_lp),
		.xscl(lcm_xscl),
		.byte_index(byte_index)
	);

endmodule

//--- lcd_scan_timing.sv
`timescale 1ns/1ps

module lcd_scan_timing import lcd_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       refresh_req,
	input  logic       clk_event,
	output logic       din,
	output logic       lp,
	output logic       xscl,
	output logic [7:0] byte_index
);

	typedef enum logic [1:0] {
		st_idle,
		st_shift_lo,
		st_shift_hi,
		st_latch
	} scan_state_t;

	scan_state_t state;
	logic [$clog2(line_bytes)-1:0] byte_cnt;
	logic [$clog2(panel_height)-1:0] line_cnt;
	logic pending;
	logic start;

	assign start = clk_event && (state == st_idle) && pending;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Refresh request holding
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pending <= 1'b0;
		end else if (start) begin
			pending <= refresh_req; // A fresh request survives the start.
		end else if (refresh_req) begin
			pending <= 1'b1;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Phase sequencer, one step per clk_event
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= st_idle;
			byte_cnt <= '0;
			line_cnt <= '0;
			din <= 1'b0;
		end else if (clk_event) begin
			case (state)
				st_idle: begin
					if (pending) begin
						state <= st_shift_lo;
						byte_cnt <= '0;
						line_cnt <= '0;
						din <= 1'b1; // Frame start marker.
					end
				end
				st_shift_lo: state <= st_shift_hi;
				st_shift_hi: begin
					if (byte_cnt == line_bytes - 1) begin
						state <= st_latch;
					end else begin
						byte_cnt <= byte_cnt + 1'b1;
						state <= st_shift_lo;
					end
				end
				st_latch: begin
					din <= 1'b0; // Drops after the first line latch.
					byte_cnt <= '0;
					if (line_cnt == panel_height - 1) begin
						line_cnt <= '0;
						state <= st_idle;
					end else begin
						line_cnt <= line_cnt + 1'b1;
						state <= st_shift_lo;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	assign xscl = (state == st_shift_hi);
	assign lp = (state == st_latch);
	assign byte_index = 8'(line_cnt * line_bytes + byte_cnt);

	a_lp_xscl_excl: assert property (
		@(posedge clk) disable iff (!rst_n)
		!(lp && xscl)
	);

endmodule

//--- lcd_reg_bus.sv
`timescale 1ns/1ps

module lcd_reg_bus import lcd_pkg::*; (
	input  logic                      clk,
	input  logic                      rst_n,

	input  logic                      wen,
	input  logic [page_addr_bits-1:0] waddr,
	input  logic [data_width-1:0]     wdata,
	input  logic [bytes_per_word-1:0] wstrb,
	input  logic                      ren,
	input  logic [page_addr_bits-1:0] raddr,
	output logic [data_width-1:0]     rdata,

	output logic                      ram_we,
	output logic [ram_addr_bits-1:0]  ram_waddr,
	output logic [data_width-1:0]     ram_wdata,
	output logic [bytes_per_word-1:0] ram_wstrb,
	output logic                      ram_re,
	output logic [ram_addr_bits-1:0]  ram_raddr,
	input  logic [data_width-1:0]     ram_rdata,

	output logic [data_width-1:0]     clk_delay,
	output logic                      byte_order,
	output logic                      refresh_req
);

	logic [page_sel_bits-1:0] read_page;
	logic [page_sel_bits-1:0] write_page;

	logic [page_sel_bits-1:0] wr_page_base;
	logic [page_sel_bits-1:0] rd_page_base;
	logic [data_width-1:0] wr_word;
	logic [data_width-1:0] rd_word;
	logic wr_in_range;
	logic rd_in_range;
	logic top_byte_wr;

	logic [data_width-1:0] reg_value;
	logic [data_width-1:0] reg_rdata;
	logic rd_sel_ram;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Page window decoding
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign wr_page_base = (write_page != 0) ? write_page - 1'b1 : '0;
	assign rd_page_base = (read_page != 0) ? read_page - 1'b1 : '0;
	assign wr_word = wr_page_base * page_words + waddr;
	assign rd_word = rd_page_base * page_words + raddr;
	assign wr_in_range = wr_word < frame_words;
	assign rd_in_range = rd_word < frame_words;
	assign top_byte_wr = wstrb[bytes_per_word-1];

	assign ram_we = wen && (write_page != 0) && wr_in_range;
	assign ram_waddr = wr_word[ram_addr_bits-1:0];
	assign ram_wdata = wdata;
	assign ram_wstrb = wstrb;
	assign ram_re = ren && (read_page != 0) && rd_in_range;
	assign ram_raddr = rd_word[ram_addr_bits-1:0];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Registers and write routing
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			clk_delay <= data_width'(min_clk_delay);
			byte_order <= 1'b0;
			read_page <= '0;
			write_page <= '0;
			refresh_req <= 1'b0;
		end else begin
			refresh_req <= 1'b0;
			if (wen && write_page == 0) begin
				case (waddr)
					reg_clk_delay: clk_delay <= (wdata < min_clk_delay) ?
						data_width'(min_clk_delay) : wdata;
					reg_byte_order: byte_order <= wdata[0];
					reg_read_page: if (wdata < num_pages) read_page <= wdata[page_sel_bits-1:0];
					reg_write_page: if (wdata < num_pages) write_page <= wdata[page_sel_bits-1:0];
					default: ;
				endcase
			end else if (ram_we && top_byte_wr) begin
				if (wr_word == frame_words - 1) begin
					write_page <= '0; // Frame complete.
					refresh_req <= 1'b1;
				end else if (waddr == page_words - 1) begin
					write_page <= '0; // End of window.
				end
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Read routing
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		reg_value = {bad_addr_tag, rd_word[data_width-byte_width-1:0]};
		if (read_page == 0) begin
			case (raddr)
				reg_clk_delay: reg_value = clk_delay;
				reg_byte_order: reg_value = data_width'(byte_order);
				reg_read_page: reg_value = data_width'(read_page);
				reg_write_page: reg_value = data_width'(write_page);
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			reg_rdata <= '0;
			rd_sel_ram <= 1'b0;
		end else if (ren) begin
			rd_sel_ram <= ram_re;
			if (!ram_re) begin
				reg_rdata <= reg_value;
			end
		end
	end

	assign rdata = rd_sel_ram ? ram_rdata : reg_rdata; // Both sides already registered.

	a_page_range: assert property (
		@(posedge clk) disable iff (!rst_n)
		(read_page < num_pages) && (write_page < num_pages)
	);

endmodule

//--- lcd_frame_ram.sv
`timescale 1ns/1ps

module lcd_frame_ram import lcd_pkg::*; (
	input  logic                      clk,

	input  logic                      we,
	input  logic [ram_addr_bits-1:0]  waddr,
	input  logic [data_width-1:0]     wdata,
	input  logic [bytes_per_word-1:0] wstrb,
	input  logic                      re,
	input  logic [ram_addr_bits-1:0]  raddr,
	output logic [data_width-1:0]     rdata,

	input  logic [7:0]                byte_index,
	input  logic                      byte_order,
	output logic [byte_width-1:0]     scan_byte
);

	logic [data_width-1:0] mem [0:frame_words-1];

	logic [ram_addr_bits-1:0] scan_word;
	logic [$clog2(bytes_per_word)-1:0] scan_lane;
	logic [byte_width-1:0] scan_raw;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Bus port
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		if (we) begin
			for (int i = 0; i < bytes_per_word; i++) begin
				if (wstrb[i]) begin
					mem[waddr][i*byte_width +: byte_width] <= wdata[i*byte_width +: byte_width];
				end
			end
		end
		if (re) begin
			rdata <= mem[raddr]; // Holds when re is low.
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Scan port
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign scan_word = ram_addr_bits'(byte_index / bytes_per_word);
	assign scan_lane = byte_index[$clog2(bytes_per_word)-1:0]; // Little endian lane.
	assign scan_raw = mem[scan_word][scan_lane*byte_width +: byte_width];

	always_comb begin
		if (byte_order) begin
			for (int b = 0; b < byte_width; b++) begin
				scan_byte[b] = scan_raw[byte_width-1-b]; // MSB first on the panel.
			end
		end else begin
			scan_byte = scan_raw;
		end
	end

	a_index_range: assert property (
		@(posedge clk) !$isunknown(byte_index) |-> byte_index < frame_bytes
	);

endmodule

//--- lcd_clk_gen.sv
`timescale 1ns/1ps

module lcd_clk_gen import lcd_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic [data_width-1:0] clk_delay,
	output logic                  panel_clk,
	output logic                  clk_event
);

	logic [data_width-1:0] cnt;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cnt <= '0;
			panel_clk <= 1'b0;
			clk_event <= 1'b0;
		end else begin
			clk_event <= 1'b0;
			if (cnt >= clk_delay - 1'b1) begin
				cnt <= '0;
				panel_clk <= ~panel_clk; // Half period done.
				clk_event <= 1'b1;
			end else begin
				cnt <= cnt + 1'b1;
			end
		end
	end

	// Consecutive events are only legal at the minimum delay.
	a_event_spacing: assert property (
		@(posedge clk) disable iff (!rst_n)
		(clk_event && clk_delay > 1) |=> !clk_event
	);

endmodule

//--- lcd_pkg.sv
package lcd_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Bus geometry
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam int unsigned data_width = 32;
	localparam int unsigned byte_width = 8;
	localparam int unsigned bytes_per_word = data_width / byte_width;

	localparam int unsigned page_addr_bits = 4;
	localparam int unsigned page_words = 1 << page_addr_bits; // Words per window.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Panel geometry
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam int unsigned panel_width = 128;
	localparam int unsigned panel_height = 8;

	localparam int unsigned line_bytes = panel_width / byte_width;
	localparam int unsigned frame_bytes = line_bytes * panel_height;
	localparam int unsigned frame_words = frame_bytes / bytes_per_word;
	localparam int unsigned ram_addr_bits = $clog2(frame_words);

	// Register page plus enough RAM pages to cover the frame.
	localparam int unsigned num_pages = 1 + (frame_words + page_words - 1) / page_words;
	localparam int unsigned page_sel_bits = $clog2(num_pages);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Register map, page 0
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam logic [page_addr_bits-1:0] reg_clk_delay = 0;
	localparam logic [page_addr_bits-1:0] reg_byte_order = 1;
	localparam logic [page_addr_bits-1:0] reg_read_page = 2;
	localparam logic [page_addr_bits-1:0] reg_write_page = 3;

	localparam int unsigned min_clk_delay = 1; // Reset value and clamp.
	localparam logic [7:0] bad_addr_tag = 8'hE0; // Top byte of unmapped reads.

endpackage
